/* all.f */
board_input_pkg.sv
input_sync.sv
debouncer.sv
edge_capture.sv
input_regs.sv
board_input_top.sv
tb_clock_gen.sv
board_input_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module board_input_tb -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

/* board_input_tb.sv */
// Testbench for the board input block: drives raw lines and register writes, checks every cycle
`timescale 1ns/10ps

module board_input_tb;

    localparam int N          = board_input_pkg::NUM_INPUTS;
    localparam int PAD        = board_input_pkg::REG_DATA_W - N;
    localparam int MAX_CYCLES = 4000;
    localparam logic [1:0] LV_LOW  = 2'd0;
    localparam logic [1:0] LV_HIGH = 2'd1;
    localparam logic [1:0] LV_ANY  = 2'd2;

    logic        clk;
    logic        rst;
    logic [N-1:0] raw_in;
    logic        reg_wr;
    logic [2:0]  reg_addr;
    logic [15:0] reg_wdata;
    logic [15:0] reg_rdata;
    logic [N-1:0] levels;
    logic        irq;

    int unsigned errors = 0;
    int unsigned cycles = 0;
    logic [31:0] rng;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------

    // Raw line one and two negedges back
    logic [N-1:0] raw_d1;
    logic [N-1:0] raw_d2;
    // Bits whose run started under an older configuration
    logic [N-1:0] fresh;
    logic [N-1:0] m_events;
    logic [N-1:0] m_clr;
    logic [N-1:0] m_mask;
    logic [N-1:0] m_prev_lv;
    logic         m_irq;
    logic [15:0]  m_div;
    logic [7:0]   m_pc;
    // Consecutive high negedges of raw_in, seen three negedges late
    int           run3 [N];

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    board_input_top DUT (
        .clk       (clk),
        .rst       (rst),
        .raw_in    (raw_in),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .levels    (levels),
        .irq       (irq)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // At most ceil(run/period) ticks fit in a run, pulse_cnt of them raise the level
    function automatic logic [1:0] expect_level(input int div, input int pc, input int run);
        int period;
        period = div + 1;
        if (run <= (pc - 1) * period) return LV_LOW;
        if (run >= (pc + 1) * period) return LV_HIGH;
        return LV_ANY;
    endfunction

    // Write strobe for one cycle, then one spare cycle for the clear to land
    task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
        @(posedge clk);
    endtask

    task automatic expect_reg(input logic [2:0] addr, input logic [15:0] want);
        reg_addr <= addr;
        @(negedge clk);
        if (reg_rdata !== want) begin
            $display("mismatch reg_rdata addr %0d: got %h expected %h", addr, reg_rdata, want);
            errors++;
        end
        @(posedge clk);
    endtask

    task automatic check_irq(input logic want);
        @(negedge clk);
        if (irq !== want) begin
            $display("mismatch irq: got %h expected %h", irq, want);
            errors++;
        end
        @(posedge clk);
    endtask

    // Counts negedges until levels match, the watchdog bounds the wait
    task automatic wait_levels(input logic [N-1:0] want, output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (levels !== want);
        @(posedge clk);
    endtask

    // ----------------------------------------
    // Comparing process
    // ----------------------------------------

    always @(negedge clk) begin : compare
        logic [1:0]   code;
        logic [15:0]  want_rd;
        logic [N-1:0] rise;
        if (rst) begin
            raw_d1    = '0;
            raw_d2    = '0;
            fresh     = '0;
            m_events  = '0;
            m_clr     = '0;
            m_mask    = '0;
            m_prev_lv = '0;
            m_irq     = 1'b0;
            m_div     = board_input_pkg::SAMPLE_DIV_RST;
            m_pc      = board_input_pkg::PULSE_CNT_RST;
            for (int i = 0; i < N; i++) run3[i] = 0;
        end else begin
            for (int i = 0; i < N; i++) begin
                // After a config change only the low rule holds until the line drops
                if (fresh[i]) code = (run3[i] == 0) ? LV_LOW : LV_ANY;
                else code = expect_level(int'(m_div), int'(m_pc), run3[i]);
                if ((code == LV_LOW && levels[i] !== 1'b0) ||
                    (code == LV_HIGH && levels[i] !== 1'b1)) begin
                    $display("mismatch levels[%0d]: got %h expected %h", i, levels[i], code[0]);
                    errors++;
                end
            end
            if (irq !== m_irq) begin
                $display("mismatch irq: got %h expected %h", irq, m_irq);
                errors++;
            end
            case (reg_addr)
                board_input_pkg::ADDR_SAMPLE_DIV: want_rd = m_div;
                board_input_pkg::ADDR_PULSE_CNT:  want_rd = {8'h00, m_pc};
                board_input_pkg::ADDR_LEVELS:     want_rd = {{PAD{1'b0}}, levels};
                board_input_pkg::ADDR_EVENTS:     want_rd = {{PAD{1'b0}}, m_events};
                board_input_pkg::ADDR_IRQ_MASK:   want_rd = {{PAD{1'b0}}, m_mask};
                default:                          want_rd = '0;
            endcase
            if (reg_rdata !== want_rd) begin
                $display("mismatch reg_rdata: got %h expected %h", reg_rdata, want_rd);
                errors++;
            end
            // Next state, as the DUT holds it after the coming edge
            rise      = levels & ~m_prev_lv;
            m_irq     = |(m_events & m_mask);
            m_events  = (m_events & ~m_clr) | rise;
            m_prev_lv = levels;
            m_clr     = '0;
            for (int i = 0; i < N; i++) begin
                run3[i] = raw_d2[i] ? run3[i] + 1 : 0;
                if (run3[i] == 0) fresh[i] = 1'b0;
            end
            raw_d2 = raw_d1;
            raw_d1 = raw_in;
            if (reg_wr) begin
                case (reg_addr)
                    board_input_pkg::ADDR_SAMPLE_DIV: begin
                        m_div = reg_wdata;
                        fresh = '1;
                    end
                    board_input_pkg::ADDR_PULSE_CNT: begin
                        // Saturated lines stay high through a lowered count
                        if (reg_wdata[7:0] <= m_pc) fresh = fresh | ~levels;
                        else fresh = '1;
                        m_pc  = reg_wdata[7:0];
                    end
                    board_input_pkg::ADDR_EVENTS:   m_clr  = reg_wdata[N-1:0];
                    board_input_pkg::ADDR_IRQ_MASK: m_mask = reg_wdata[N-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT never reached the awaited levels", cycles);
            $display("Errors: %0d", errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin : stimulus
        int           n;
        logic [N-1:0] seen;
        rng       = 32'd29;
        raw_in    = '0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        @(posedge clk);
        while (rst) @(posedge clk);

        // Reset values, readback, ignored write to levels
        expect_reg(board_input_pkg::ADDR_SAMPLE_DIV, board_input_pkg::SAMPLE_DIV_RST);
        expect_reg(board_input_pkg::ADDR_PULSE_CNT, 16'(board_input_pkg::PULSE_CNT_RST));
        expect_reg(board_input_pkg::ADDR_EVENTS, 16'h0000);
        expect_reg(board_input_pkg::ADDR_IRQ_MASK, 16'h0000);
        expect_reg(3'd7, 16'h0000);
        write_reg(board_input_pkg::ADDR_SAMPLE_DIV, 16'h1234);
        expect_reg(board_input_pkg::ADDR_SAMPLE_DIV, 16'h1234);
        write_reg(board_input_pkg::ADDR_IRQ_MASK, 16'h005A);
        expect_reg(board_input_pkg::ADDR_IRQ_MASK, 16'h005A);
        write_reg(board_input_pkg::ADDR_LEVELS, 16'h00FF);
        expect_reg(board_input_pkg::ADDR_LEVELS, 16'h0000);
        write_reg(board_input_pkg::ADDR_IRQ_MASK, 16'h0000);
        write_reg(board_input_pkg::ADDR_SAMPLE_DIV, 16'd3);
        write_reg(board_input_pkg::ADDR_PULSE_CNT, 16'd4);
        expect_reg(board_input_pkg::ADDR_PULSE_CNT, 16'd4);

        // Bounce, runs of 7 cycles at most, 13 would be needed for 4 ticks
        seen = '0;
        for (int k = 0; k < 240; k++) begin
            rng = xorshift(rng);
            raw_in <= (k % 8 == 7) ? '0 : rng[N-1:0];
            @(negedge clk);
            seen = seen | levels;
            @(posedge clk);
        end
        if (seen !== '0) begin
            $display("mismatch levels during bounce: got %h expected %h", seen, 8'h00);
            errors++;
        end

        // Several lines held high, two of them released
        raw_in <= 8'hA5;
        wait_levels(8'hA5, n);
        if (n > 5 * 4 + 3) begin
            $display("Debounce delay of %0d cycles is over the limit of %0d", n, 23);
            errors++;
        end
        raw_in <= 8'h05;
        wait_levels(8'h05, n);
        // Two sync stages plus the counter clear
        if (n > 4) begin
            $display("Release took %0d cycles, more than 4", n);
            errors++;
        end

        // Sticky events, partial clear, irq unmask on a set event
        expect_reg(board_input_pkg::ADDR_EVENTS, 16'h00A5);
        write_reg(board_input_pkg::ADDR_EVENTS, 16'h0021);
        expect_reg(board_input_pkg::ADDR_EVENTS, 16'h0084);
        check_irq(1'b0);
        write_reg(board_input_pkg::ADDR_IRQ_MASK, 16'h0004);
        check_irq(1'b1);
        write_reg(board_input_pkg::ADDR_EVENTS, 16'h0084);
        @(posedge clk);
        check_irq(1'b0);

        // Lower pulse_cnt under held lines, then a slower tick
        raw_in <= 8'h0F;
        wait_levels(8'h0F, n);
        write_reg(board_input_pkg::ADDR_PULSE_CNT, 16'd2);
        @(posedge clk);
        expect_reg(board_input_pkg::ADDR_LEVELS, 16'h000F);
        raw_in <= '0;
        wait_levels('0, n);
        write_reg(board_input_pkg::ADDR_SAMPLE_DIV, 16'd9);
        raw_in <= 8'hF0;
        wait_levels(8'hF0, n);
        if (n > 3 * 10 + 3) begin
            $display("Debounce delay of %0d cycles is over the limit of %0d", n, 33);
            errors++;
        end
        raw_in <= '0;
        repeat (4) @(posedge clk);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source, 8 ns period with reset held for three cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 125 MHz board clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Released on a rising edge, seen by the DUT one edge later
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* board_input_top.sv */
// Top level of the board input block, connecting synchronizer, debouncer, edge stage and registers
`timescale 1ns/10ps

module board_input_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [board_input_pkg::NUM_INPUTS-1:0] raw_in,
    input  logic                                 reg_wr,
    input  logic [board_input_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [board_input_pkg::REG_DATA_W-1:0] reg_wdata,
    output logic [board_input_pkg::REG_DATA_W-1:0] reg_rdata,
    output logic [board_input_pkg::NUM_INPUTS-1:0] levels,
    output logic                                 irq
);

    // ----------------------------------------
    // Internal nets
    // ----------------------------------------

    logic [board_input_pkg::NUM_INPUTS-1:0]   sync_in;
    logic [board_input_pkg::SAMPLE_DIV_W-1:0] sample_div;
    logic [board_input_pkg::PULSE_CNT_W-1:0]  pulse_cnt;
    logic [board_input_pkg::NUM_INPUTS-1:0]   irq_mask;
    logic [board_input_pkg::NUM_INPUTS-1:0]   event_clr;
    logic [board_input_pkg::NUM_INPUTS-1:0]   events;

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    // Raw lines into clk domain
    input_sync u_input_sync (
        .clk     (clk),
        .rst     (rst),
        .raw_in  (raw_in),
        .sync_in (sync_in)
    );

    // Debounced levels also go straight out
    debouncer u_debouncer (
        .clk        (clk),
        .rst        (rst),
        .sync_in    (sync_in),
        .sample_div (sample_div),
        .pulse_cnt  (pulse_cnt),
        .levels     (levels)
    );

    edge_capture u_edge_capture (
        .clk       (clk),
        .rst       (rst),
        .levels    (levels),
        .event_clr (event_clr),
        .irq_mask  (irq_mask),
        .events    (events),
        .irq       (irq)
    );

    // Software side
    input_regs u_input_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .levels     (levels),
        .events     (events),
        .sample_div (sample_div),
        .pulse_cnt  (pulse_cnt),
        .irq_mask   (irq_mask),
        .event_clr  (event_clr)
    );

endmodule

/* input_regs.sv */
// Register block holding debounce configuration and interrupt mask, with status reads and clears
`timescale 1ns/10ps

module input_regs (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   reg_wr,
    input  logic [board_input_pkg::REG_ADDR_W-1:0]   reg_addr,
    input  logic [board_input_pkg::REG_DATA_W-1:0]   reg_wdata,
    output logic [board_input_pkg::REG_DATA_W-1:0]   reg_rdata,
    input  logic [board_input_pkg::NUM_INPUTS-1:0]   levels,
    input  logic [board_input_pkg::NUM_INPUTS-1:0]   events,
    output logic [board_input_pkg::SAMPLE_DIV_W-1:0] sample_div,
    output logic [board_input_pkg::PULSE_CNT_W-1:0]  pulse_cnt,
    output logic [board_input_pkg::NUM_INPUTS-1:0]   irq_mask,
    output logic [board_input_pkg::NUM_INPUTS-1:0]   event_clr
);

    // Zero padding for narrow fields on the read bus
    localparam int PAD_PULSE = board_input_pkg::REG_DATA_W - board_input_pkg::PULSE_CNT_W;
    localparam int PAD_BITS  = board_input_pkg::REG_DATA_W - board_input_pkg::NUM_INPUTS;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------

    logic wr_sample_div;
    logic wr_pulse_cnt;
    logic wr_events;
    logic wr_irq_mask;

    assign wr_sample_div = reg_wr && (reg_addr == board_input_pkg::ADDR_SAMPLE_DIV);
    assign wr_pulse_cnt  = reg_wr && (reg_addr == board_input_pkg::ADDR_PULSE_CNT);
    assign wr_events     = reg_wr && (reg_addr == board_input_pkg::ADDR_EVENTS);
    assign wr_irq_mask   = reg_wr && (reg_addr == board_input_pkg::ADDR_IRQ_MASK);

    // Configuration, live on the cycle after the write
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_div <= board_input_pkg::SAMPLE_DIV_RST;
            pulse_cnt  <= board_input_pkg::PULSE_CNT_RST;
            irq_mask   <= '0;
        end else begin
            if (wr_sample_div) begin
                sample_div <= reg_wdata[board_input_pkg::SAMPLE_DIV_W-1:0];
            end
            if (wr_pulse_cnt) begin
                pulse_cnt <= reg_wdata[board_input_pkg::PULSE_CNT_W-1:0];
            end
            if (wr_irq_mask) begin
                irq_mask <= reg_wdata[board_input_pkg::NUM_INPUTS-1:0];
            end
        end
    end

    // ----------------------------------------
    // Event clear strobe
    // ----------------------------------------

    // One cycle wide, low bits of the write data
    always_ff @(posedge clk) begin
        if (rst) begin
            event_clr <= '0;
        end else if (wr_events) begin
            event_clr <= reg_wdata[board_input_pkg::NUM_INPUTS-1:0];
        end else begin
            event_clr <= '0;
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------

    always_comb begin
        case (reg_addr)
            board_input_pkg::ADDR_SAMPLE_DIV: reg_rdata = sample_div;
            board_input_pkg::ADDR_PULSE_CNT:  reg_rdata = {{PAD_PULSE{1'b0}}, pulse_cnt};
            board_input_pkg::ADDR_LEVELS:     reg_rdata = {{PAD_BITS{1'b0}}, levels};
            board_input_pkg::ADDR_EVENTS:     reg_rdata = {{PAD_BITS{1'b0}}, events};
            board_input_pkg::ADDR_IRQ_MASK:   reg_rdata = {{PAD_BITS{1'b0}}, irq_mask};
            // Unmapped
            default:                          reg_rdata = '0;
        endcase
    end

    // Strobe only ever follows an events write
    a_clr_source: assert property (@(posedge clk) disable iff (rst)
        (event_clr != '0) |-> $past(wr_events));

endmodule

/* edge_capture.sv */
// Rising-edge detector with sticky event bits, write-one-to-clear and a masked interrupt
`timescale 1ns/10ps

module edge_capture (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [board_input_pkg::NUM_INPUTS-1:0] levels,
    input  logic [board_input_pkg::NUM_INPUTS-1:0] event_clr,
    input  logic [board_input_pkg::NUM_INPUTS-1:0] irq_mask,
    output logic [board_input_pkg::NUM_INPUTS-1:0] events,
    output logic                                 irq
);

    // ----------------------------------------
    // Edge detection
    // ----------------------------------------

    logic [board_input_pkg::NUM_INPUTS-1:0] levels_q;
    logic [board_input_pkg::NUM_INPUTS-1:0] rise;

    // Current high, previous low
    assign rise = levels & ~levels_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            levels_q <= '0;
        end else begin
            levels_q <= levels;
        end
    end

    // ----------------------------------------
    // Sticky events and interrupt
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            events <= '0;
            irq    <= 1'b0;
        end else begin
            // Set wins over clear in the same cycle
            events <= (events & ~event_clr) | rise;
            // Registered, one cycle behind events
            irq    <= |(events & irq_mask);
        end
    end

    // Only software clears an event, through the register block
    a_event_hold: assert property (@(posedge clk) disable iff (rst)
        ((~events & $past(events) & ~$past(event_clr)) == '0));

endmodule

/* debouncer.sv */
// Debouncer with one shared sample tick and one saturating counter per input bit
`timescale 1ns/10ps

module debouncer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [board_input_pkg::NUM_INPUTS-1:0]   sync_in,
    input  logic [board_input_pkg::SAMPLE_DIV_W-1:0] sample_div,
    input  logic [board_input_pkg::PULSE_CNT_W-1:0]  pulse_cnt,
    output logic [board_input_pkg::NUM_INPUTS-1:0]   levels
);

    // ----------------------------------------
    // Sample tick
    // ----------------------------------------

    logic [board_input_pkg::SAMPLE_DIV_W-1:0] wrap_cnt;
    logic                                     tick;

    // Greater-or-equal so a lowered divisor still wraps
    assign tick = (wrap_cnt >= sample_div);

    always_ff @(posedge clk) begin
        if (rst) begin
            wrap_cnt <= '0;
        end else if (tick) begin
            wrap_cnt <= '0;
        end else begin
            wrap_cnt <= wrap_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Per-bit saturating counters
    // ----------------------------------------

    logic [board_input_pkg::PULSE_CNT_W-1:0] sat_cnt [board_input_pkg::NUM_INPUTS];

    for (genvar i = 0; i < board_input_pkg::NUM_INPUTS; i++) begin : g_bit

        always_ff @(posedge clk) begin
            if (rst || !sync_in[i]) begin
                // Any low sample restarts the count
                sat_cnt[i] <= '0;
            end else if (sat_cnt[i] > pulse_cnt) begin
                // Saturation count lowered under us
                sat_cnt[i] <= pulse_cnt;
            end else if (tick && (sat_cnt[i] < pulse_cnt)) begin
                sat_cnt[i] <= sat_cnt[i] + 1'b1;
            end
        end

        // Level high while saturated, and through the overshoot of a lowered pulse_cnt
        assign levels[i] = (sat_cnt[i] >= pulse_cnt);

        // Overshoot from a lowered pulse_cnt lasts one cycle at most
        a_sat_bound: assert property (@(posedge clk) disable iff (rst)
            (sat_cnt[i] > pulse_cnt) |=> (sat_cnt[i] <= pulse_cnt));
    end

    // Tick is a single-cycle pulse unless the divisor is zero
    a_tick_pulse: assert property (@(posedge clk) disable iff (rst)
        tick |=> (!tick || (sample_div == '0)));

endmodule

/* input_sync.sv */
// Two-flop synchronizer that brings the asynchronous board lines into the clk domain
`timescale 1ns/10ps

module input_sync (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [board_input_pkg::NUM_INPUTS-1:0] raw_in,
    output logic [board_input_pkg::NUM_INPUTS-1:0] sync_in
);

    // ----------------------------------------
    // Synchronizer stages
    // ----------------------------------------

    // First stage may go metastable
    logic [board_input_pkg::NUM_INPUTS-1:0] meta_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_q  <= '0;
            sync_in <= '0;
        end else begin
            // Raw line to meta stage
            meta_q  <= raw_in;
            // Settled copy, two edges after raw_in
            sync_in <= meta_q;
        end
    end

    // No logic between the two stages, the full period is for settling

endmodule

/* board_input_pkg.sv */
// Shared widths, register map and reset values for the board input block; referenced by scope
package board_input_pkg;

    // ----------------------------------------
    // Datapath widths
    // ----------------------------------------

    // Push-buttons plus switches
    localparam int NUM_INPUTS   = 8;

    // Sample divisor and wrapping counter
    localparam int SAMPLE_DIV_W = 16;

    // Saturation count and per-bit counters
    localparam int PULSE_CNT_W  = 8;

    // ----------------------------------------
    // Register port
    // ----------------------------------------

    localparam int REG_ADDR_W   = 3;
    localparam int REG_DATA_W   = 16;

    // Register map
    localparam logic [REG_ADDR_W-1:0] ADDR_SAMPLE_DIV = 3'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_PULSE_CNT  = 3'd1;
    // Read only, writes dropped
    localparam logic [REG_ADDR_W-1:0] ADDR_LEVELS     = 3'd2;
    // Write one to clear
    localparam logic [REG_ADDR_W-1:0] ADDR_EVENTS     = 3'd3;
    localparam logic [REG_ADDR_W-1:0] ADDR_IRQ_MASK   = 3'd4;

    // ----------------------------------------
    // Configuration reset values
    // ----------------------------------------

    // Tick every 25000 cycles
    localparam logic [SAMPLE_DIV_W-1:0] SAMPLE_DIV_RST = 16'd24999;
    // Ticks of stable high before a level rises
    localparam logic [PULSE_CNT_W-1:0]  PULSE_CNT_RST  = 8'd150;

endpackage
